/* design/vpipe_pkg.sv */
package vpipe_pkg;

   // ************************************************************************
   // widths
   // ************************************************************************
   localparam int instr_width = 21;
   localparam int reg_index_width = 3;
   localparam int scalar_width = 8;
   localparam int lane_count = 16;
   localparam int vector_width = 128;
   localparam int queue_depth = 4;
   localparam int queue_ptr_width = 2;
   localparam int queue_count_width = 3;
   localparam int stall_count_width = 2;

   // instruction fields from the top: opcode 4, rd 3, rs1 3, rs2 3, imm 8
   localparam int opcode_width = 4;
   localparam int opcode_lsb = 17;
   localparam int rd_lsb = 14;
   localparam int rs1_lsb = 11;
   localparam int rs2_lsb = 8;
   localparam int imm_lsb = 0;

   // timer load values, one less than the stall length in cycles
   localparam logic [stall_count_width-1:0] stall_de_count = 2'd1;
   localparam logic [stall_count_width-1:0] stall_wb_count = 2'd0;

   typedef enum logic [3:0] {
      op_nop    = 4'd0,   // all-zero word decodes as a nop
      op_add    = 4'd1,
      op_sub    = 4'd2,
      op_and    = 4'd3,
      op_or     = 4'd4,
      op_xor    = 4'd5,
      op_li     = 4'd6,
      op_vadd   = 4'd7,
      op_vsub   = 4'd8,
      op_vxor   = 4'd9,
      op_vsplat = 4'd10
   } opcode_t;

   typedef enum logic [2:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_pass_a, alu_pass_imm
   } alu_op_t;

   typedef enum logic [1:0] {
      st_run, st_stall
   } hazard_state_t;

endpackage

/* design/instr_queue.sv */
`timescale 1ns/100ps

module instr_queue (
   input  logic clk,
   input  logic reset,
   input  logic instr_valid,
   input  logic [vpipe_pkg::instr_width-1:0] instr,
   input  logic pop,
   output logic queue_valid,
   output logic [vpipe_pkg::instr_width-1:0] queue_instr,
   output logic credit_return
);

   logic [vpipe_pkg::instr_width-1:0] entries [vpipe_pkg::queue_depth];
   logic [vpipe_pkg::queue_ptr_width-1:0] write_ptr;
   logic [vpipe_pkg::queue_ptr_width-1:0] read_ptr;
   logic [vpipe_pkg::queue_count_width-1:0] count;

   always_ff @(posedge clk) begin
      if (reset) begin
         write_ptr <= '0;
         read_ptr <= '0;
         count <= '0;
         credit_return <= 1'b0;
      end else begin
         if (instr_valid) write_ptr <= write_ptr + 1'b1;
         if (pop) read_ptr <= read_ptr + 1'b1;
         count <= count + instr_valid - pop;
         credit_return <= pop;   // slot freed, hand the credit back
      end
   end

   always_ff @(posedge clk) begin
      if (instr_valid) entries[write_ptr] <= instr;
   end

   assign queue_valid = (count != '0);
   // an empty queue presents an all-zero word so decode sees a nop
   assign queue_instr = queue_valid ? entries[read_ptr] : '0;

   // the sender must hold a credit, so a push never lands on a full queue
   a_no_push_full: assert property (@(posedge clk) disable iff (reset)
      instr_valid |-> count != vpipe_pkg::queue_depth);

   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      pop |-> queue_valid);

endmodule

/* design/stall_timer.sv */
`timescale 1ns/100ps

module stall_timer (
   input  logic clk,
   input  logic reset,
   input  logic timer_load,
   input  logic [vpipe_pkg::stall_count_width-1:0] timer_value,
   output logic timer_done
);

   logic [vpipe_pkg::stall_count_width-1:0] count;

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (timer_load) begin
         count <= timer_value;
      end else if (count != '0) begin
         count <= count - 1'b1;
      end
   end

   assign timer_done = (count == '0) && !timer_load;

endmodule

/* design/hazard_fsm.sv */
`timescale 1ns/100ps

module hazard_fsm (
   input  logic clk,
   input  logic reset,
   input  logic queue_valid,
   input  logic [vpipe_pkg::reg_index_width-1:0] src1_index,
   input  logic [vpipe_pkg::reg_index_width-1:0] src2_index,
   input  logic src1_used,
   input  logic src2_used,
   input  logic src1_vector,
   input  logic src2_vector,
   input  logic [vpipe_pkg::reg_index_width-1:0] de_rd,
   input  logic de_writes,
   input  logic de_vector,
   input  logic [vpipe_pkg::reg_index_width-1:0] wb_rd,
   input  logic wb_writes,
   input  logic wb_vector,
   input  logic timer_done,
   output logic stall,
   output logic timer_load,
   output logic [vpipe_pkg::stall_count_width-1:0] timer_value
);

   vpipe_pkg::hazard_state_t state, next_state;
   logic hit_de;
   logic hit_wb;

   // a source hits only if the register class matches as well as the index
   function automatic logic src_hit(input logic used, input logic vector,
                                    input logic [vpipe_pkg::reg_index_width-1:0] index,
                                    input logic writes, input logic dst_vector,
                                    input logic [vpipe_pkg::reg_index_width-1:0] dst);
      return used && writes && (vector == dst_vector) && (index == dst);
   endfunction

   assign hit_de = src_hit(src1_used, src1_vector, src1_index, de_writes, de_vector, de_rd)
                || src_hit(src2_used, src2_vector, src2_index, de_writes, de_vector, de_rd);
   assign hit_wb = src_hit(src1_used, src1_vector, src1_index, wb_writes, wb_vector, wb_rd)
                || src_hit(src2_used, src2_vector, src2_index, wb_writes, wb_vector, wb_rd);

   always_ff @(posedge clk) begin
      if (reset) state <= vpipe_pkg::st_run;
      else state <= next_state;
   end

   always_comb begin
      next_state = state;
      stall = 1'b0;
      timer_load = 1'b0;
      timer_value = vpipe_pkg::stall_wb_count;
      case (state)
         vpipe_pkg::st_run: begin
            if (queue_valid && (hit_de || hit_wb)) begin
               stall = 1'b1;
               timer_load = 1'b1;
               // the older writer in execute needs one more cycle than writeback
               if (hit_de) timer_value = vpipe_pkg::stall_de_count;
               next_state = vpipe_pkg::st_stall;
            end
         end
         default: begin
            stall = !timer_done;
            if (timer_done) next_state = vpipe_pkg::st_run;
         end
      endcase
   end

   // decode is released only once no writer of its sources is still in flight
   a_no_hazard_on_release: assert property (@(posedge clk) disable iff (reset)
      state == vpipe_pkg::st_stall && timer_done |-> !(hit_de || hit_wb));

endmodule

/* design/register_file.sv */
`timescale 1ns/100ps

module register_file (
   input  logic clk,
   input  logic reset,
   input  logic [vpipe_pkg::reg_index_width-1:0] read_index1,
   input  logic [vpipe_pkg::reg_index_width-1:0] read_index2,
   output logic [vpipe_pkg::scalar_width-1:0] scalar_read1,
   output logic [vpipe_pkg::scalar_width-1:0] scalar_read2,
   output logic [vpipe_pkg::vector_width-1:0] vector_read1,
   output logic [vpipe_pkg::vector_width-1:0] vector_read2,
   input  logic write_enable,
   input  logic write_vector,
   input  logic [vpipe_pkg::reg_index_width-1:0] write_index,
   input  logic [vpipe_pkg::vector_width-1:0] write_data
);

   localparam int reg_count = 2 ** vpipe_pkg::reg_index_width;

   logic [vpipe_pkg::scalar_width-1:0] scalar_regs [reg_count];
   logic [vpipe_pkg::vector_width-1:0] vector_regs [reg_count];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < reg_count; i++) begin
            scalar_regs[i] <= '0;
            vector_regs[i] <= '0;
         end
      end else if (write_enable) begin
         if (write_vector) vector_regs[write_index] <= write_data;
         else scalar_regs[write_index] <= write_data[vpipe_pkg::scalar_width-1:0];
      end
   end

   // reads see the old value during the writeback cycle
   assign scalar_read1 = scalar_regs[read_index1];
   assign scalar_read2 = scalar_regs[read_index2];
   assign vector_read1 = vector_regs[read_index1];
   assign vector_read2 = vector_regs[read_index2];

endmodule

/* design/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
   input  logic [vpipe_pkg::instr_width-1:0] queue_instr,
   output logic [vpipe_pkg::reg_index_width-1:0] read_index1,
   output logic [vpipe_pkg::reg_index_width-1:0] read_index2,
   input  logic [vpipe_pkg::scalar_width-1:0] scalar_read1,
   input  logic [vpipe_pkg::scalar_width-1:0] scalar_read2,
   input  logic [vpipe_pkg::vector_width-1:0] vector_read1,
   input  logic [vpipe_pkg::vector_width-1:0] vector_read2,
   output logic [vpipe_pkg::reg_index_width-1:0] src1_index,
   output logic [vpipe_pkg::reg_index_width-1:0] src2_index,
   output logic src1_used,
   output logic src2_used,
   output logic src1_vector,
   output logic src2_vector,
   output logic dec_writes,
   output logic dec_vector,
   output logic [vpipe_pkg::reg_index_width-1:0] dec_rd,
   output vpipe_pkg::alu_op_t dec_alu_op,
   output logic [vpipe_pkg::scalar_width-1:0] dec_imm,
   output logic [vpipe_pkg::vector_width-1:0] dec_src_a,
   output logic [vpipe_pkg::vector_width-1:0] dec_src_b
);

   vpipe_pkg::opcode_t opcode;

   assign opcode = vpipe_pkg::opcode_t'(queue_instr[vpipe_pkg::opcode_lsb +: vpipe_pkg::opcode_width]);
   assign dec_rd = queue_instr[vpipe_pkg::rd_lsb +: vpipe_pkg::reg_index_width];
   assign read_index1 = queue_instr[vpipe_pkg::rs1_lsb +: vpipe_pkg::reg_index_width];
   assign read_index2 = queue_instr[vpipe_pkg::rs2_lsb +: vpipe_pkg::reg_index_width];
   assign dec_imm = queue_instr[vpipe_pkg::imm_lsb +: vpipe_pkg::scalar_width];
   assign src1_index = read_index1;
   assign src2_index = read_index2;

   // ************************************************************************
   // opcode to control
   // ************************************************************************
   always_comb begin
      dec_writes = 1'b1;
      dec_vector = 1'b0;
      dec_alu_op = vpipe_pkg::alu_add;
      src1_used = 1'b1;
      src2_used = 1'b1;
      src1_vector = 1'b0;
      src2_vector = 1'b0;
      case (opcode)
         vpipe_pkg::op_add:    dec_alu_op = vpipe_pkg::alu_add;
         vpipe_pkg::op_sub:    dec_alu_op = vpipe_pkg::alu_sub;
         vpipe_pkg::op_and:    dec_alu_op = vpipe_pkg::alu_and;
         vpipe_pkg::op_or:     dec_alu_op = vpipe_pkg::alu_or;
         vpipe_pkg::op_xor:    dec_alu_op = vpipe_pkg::alu_xor;
         vpipe_pkg::op_li: begin
            dec_alu_op = vpipe_pkg::alu_pass_imm;
            src1_used = 1'b0;
            src2_used = 1'b0;
         end
         vpipe_pkg::op_vadd, vpipe_pkg::op_vsub, vpipe_pkg::op_vxor: begin
            dec_vector = 1'b1;
            src1_vector = 1'b1;
            src2_vector = 1'b1;
            if (opcode == vpipe_pkg::op_vsub) dec_alu_op = vpipe_pkg::alu_sub;
            else if (opcode == vpipe_pkg::op_vxor) dec_alu_op = vpipe_pkg::alu_xor;
         end
         vpipe_pkg::op_vsplat: begin
            dec_vector = 1'b1;   // scalar source, vector destination
            dec_alu_op = vpipe_pkg::alu_pass_a;
            src2_used = 1'b0;
         end
         default: begin   // nop and unused codes write nothing
            dec_writes = 1'b0;
            src1_used = 1'b0;
            src2_used = 1'b0;
         end
      endcase
   end

   always_comb begin
      dec_src_a = src1_vector ? vector_read1 : vpipe_pkg::vector_width'(scalar_read1);
      dec_src_b = src2_vector ? vector_read2 : vpipe_pkg::vector_width'(scalar_read2);
      if (opcode == vpipe_pkg::op_vsplat) dec_src_a = {vpipe_pkg::lane_count{scalar_read1}};
   end

endmodule

/* design/decode_execute_register.sv */
`timescale 1ns/100ps

module decode_execute_register (
   input  logic clk,
   input  logic reset,
   input  logic bubble,
   input  logic dec_writes,
   input  logic dec_vector,
   input  logic [vpipe_pkg::reg_index_width-1:0] dec_rd,
   input  vpipe_pkg::alu_op_t dec_alu_op,
   input  logic [vpipe_pkg::scalar_width-1:0] dec_imm,
   input  logic [vpipe_pkg::vector_width-1:0] dec_src_a,
   input  logic [vpipe_pkg::vector_width-1:0] dec_src_b,
   output logic de_writes,
   output logic de_vector,
   output logic [vpipe_pkg::reg_index_width-1:0] de_rd,
   output vpipe_pkg::alu_op_t de_alu_op,
   output logic [vpipe_pkg::scalar_width-1:0] de_imm,
   output logic [vpipe_pkg::vector_width-1:0] de_src_a,
   output logic [vpipe_pkg::vector_width-1:0] de_src_b
);

   // control half, a bubble is a nop with the write flag clear
   always_ff @(posedge clk) begin
      if (reset || bubble) begin
         de_writes <= 1'b0;
         de_vector <= 1'b0;
         de_rd <= '0;
         de_alu_op <= vpipe_pkg::alu_add;
      end else begin
         de_writes <= dec_writes;
         de_vector <= dec_vector;
         de_rd <= dec_rd;
         de_alu_op <= dec_alu_op;
      end
   end

   always_ff @(posedge clk) begin
      de_imm <= dec_imm;
      de_src_a <= dec_src_a;
      de_src_b <= dec_src_b;
   end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
   input  logic clk,
   input  logic reset,
   input  logic de_writes,
   input  logic de_vector,
   input  logic [vpipe_pkg::reg_index_width-1:0] de_rd,
   input  vpipe_pkg::alu_op_t de_alu_op,
   input  logic [vpipe_pkg::scalar_width-1:0] de_imm,
   input  logic [vpipe_pkg::vector_width-1:0] de_src_a,
   input  logic [vpipe_pkg::vector_width-1:0] de_src_b,
   output logic wb_valid,
   output logic wb_vector,
   output logic [vpipe_pkg::reg_index_width-1:0] wb_rd,
   output logic [vpipe_pkg::vector_width-1:0] wb_data
);

   localparam int sw = vpipe_pkg::scalar_width;

   logic [vpipe_pkg::vector_width-1:0] result;

   function automatic logic [sw-1:0] lane_alu(input vpipe_pkg::alu_op_t op,
                                              input logic [sw-1:0] a, input logic [sw-1:0] b,
                                              input logic [sw-1:0] imm);
      case (op)
         vpipe_pkg::alu_sub:      return a - b;
         vpipe_pkg::alu_and:      return a & b;
         vpipe_pkg::alu_or:       return a | b;
         vpipe_pkg::alu_xor:      return a ^ b;
         vpipe_pkg::alu_pass_a:   return a;
         vpipe_pkg::alu_pass_imm: return imm;
         default:                 return a + b;   // wraps within the lane
      endcase
   endfunction

   // ************************************************************************
   // sixteen independent lanes, no carry between them
   // ************************************************************************
   always_comb begin
      for (int i = 0; i < vpipe_pkg::lane_count; i++) begin
         result[i*sw +: sw] = lane_alu(de_alu_op, de_src_a[i*sw +: sw], de_src_b[i*sw +: sw],
                                       de_imm);
      end
      if (!de_vector) result[vpipe_pkg::vector_width-1:sw] = '0;   // scalar uses lane 0
   end

   always_ff @(posedge clk) begin
      if (reset) wb_valid <= 1'b0;
      else wb_valid <= de_writes;
   end

   always_ff @(posedge clk) begin
      wb_vector <= de_vector;
      wb_rd <= de_rd;
      wb_data <= result;
   end

endmodule

/* design/vector_pipeline.sv */
`timescale 1ns/100ps

module vector_pipeline (
   input  logic clk,
   input  logic reset,
   input  logic instr_valid,
   input  logic [vpipe_pkg::instr_width-1:0] instr,
   output logic credit_return,
   output logic wb_valid,
   output logic wb_vector,
   output logic [vpipe_pkg::reg_index_width-1:0] wb_rd,
   output logic [vpipe_pkg::vector_width-1:0] wb_data
);

   logic queue_valid;
   logic pop;
   logic stall;
   logic timer_load;
   logic timer_done;
   logic [vpipe_pkg::stall_count_width-1:0] timer_value;
   logic [vpipe_pkg::instr_width-1:0] queue_instr;
   logic [vpipe_pkg::reg_index_width-1:0] read_index1, read_index2;
   logic [vpipe_pkg::scalar_width-1:0] scalar_read1, scalar_read2;
   logic [vpipe_pkg::vector_width-1:0] vector_read1, vector_read2;
   logic [vpipe_pkg::reg_index_width-1:0] src1_index, src2_index;
   logic src1_used, src2_used, src1_vector, src2_vector;
   logic dec_writes, dec_vector, de_writes, de_vector;
   logic [vpipe_pkg::reg_index_width-1:0] dec_rd, de_rd;
   vpipe_pkg::alu_op_t dec_alu_op, de_alu_op;
   logic [vpipe_pkg::scalar_width-1:0] dec_imm, de_imm;
   logic [vpipe_pkg::vector_width-1:0] dec_src_a, dec_src_b, de_src_a, de_src_b;

   assign pop = queue_valid && !stall;   // head leaves unless decode is held

   instr_queue u_instr_queue (
      .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr), .pop(pop),
      .queue_valid(queue_valid), .queue_instr(queue_instr), .credit_return(credit_return)
   );

   register_file u_register_file (
      .clk(clk), .reset(reset), .read_index1(read_index1), .read_index2(read_index2),
      .scalar_read1(scalar_read1), .scalar_read2(scalar_read2),
      .vector_read1(vector_read1), .vector_read2(vector_read2),
      .write_enable(wb_valid), .write_vector(wb_vector), .write_index(wb_rd),
      .write_data(wb_data)
   );

   decode_stage u_decode_stage (
      .queue_instr(queue_instr), .read_index1(read_index1), .read_index2(read_index2),
      .scalar_read1(scalar_read1), .scalar_read2(scalar_read2),
      .vector_read1(vector_read1), .vector_read2(vector_read2),
      .src1_index(src1_index), .src2_index(src2_index),
      .src1_used(src1_used), .src2_used(src2_used),
      .src1_vector(src1_vector), .src2_vector(src2_vector),
      .dec_writes(dec_writes), .dec_vector(dec_vector), .dec_rd(dec_rd),
      .dec_alu_op(dec_alu_op), .dec_imm(dec_imm),
      .dec_src_a(dec_src_a), .dec_src_b(dec_src_b)
   );

   hazard_fsm u_hazard_fsm (
      .clk(clk), .reset(reset), .queue_valid(queue_valid),
      .src1_index(src1_index), .src2_index(src2_index),
      .src1_used(src1_used), .src2_used(src2_used),
      .src1_vector(src1_vector), .src2_vector(src2_vector),
      .de_rd(de_rd), .de_writes(de_writes), .de_vector(de_vector),
      .wb_rd(wb_rd), .wb_writes(wb_valid), .wb_vector(wb_vector),
      .timer_done(timer_done), .stall(stall),
      .timer_load(timer_load), .timer_value(timer_value)
   );

   stall_timer u_stall_timer (
      .clk(clk), .reset(reset), .timer_load(timer_load), .timer_value(timer_value),
      .timer_done(timer_done)
   );

   decode_execute_register u_decode_execute_register (
      .clk(clk), .reset(reset), .bubble(stall),
      .dec_writes(dec_writes), .dec_vector(dec_vector), .dec_rd(dec_rd),
      .dec_alu_op(dec_alu_op), .dec_imm(dec_imm),
      .dec_src_a(dec_src_a), .dec_src_b(dec_src_b),
      .de_writes(de_writes), .de_vector(de_vector), .de_rd(de_rd),
      .de_alu_op(de_alu_op), .de_imm(de_imm),
      .de_src_a(de_src_a), .de_src_b(de_src_b)
   );

   execute_stage u_execute_stage (
      .clk(clk), .reset(reset),
      .de_writes(de_writes), .de_vector(de_vector), .de_rd(de_rd),
      .de_alu_op(de_alu_op), .de_imm(de_imm),
      .de_src_a(de_src_a), .de_src_b(de_src_b),
      .wb_valid(wb_valid), .wb_vector(wb_vector), .wb_rd(wb_rd), .wb_data(wb_data)
   );

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* sim/vector_pipeline_tb.sv */
`timescale 1ns/100ps

module vector_pipeline_tb;

   logic clk;
   logic reset;
   logic instr_valid;
   logic [vpipe_pkg::instr_width-1:0] instr;
   logic credit_return;
   logic wb_valid;
   logic wb_vector;
   logic [vpipe_pkg::reg_index_width-1:0] wb_rd;
   logic [vpipe_pkg::vector_width-1:0] wb_data;

   // stimulus table with one row per instruction
   vpipe_pkg::opcode_t tbl_op [$];
   logic [2:0] tbl_rd [$];
   logic [2:0] tbl_rs1 [$];
   logic [2:0] tbl_rs2 [$];
   logic tbl_burst [$];   // pushed right after the previous row

   // reference model state and the results still owed by the DUT
   logic [vpipe_pkg::scalar_width-1:0] sregs [8];
   logic [vpipe_pkg::vector_width-1:0] vregs [8];
   logic [2:0] exp_rd [$];
   logic exp_vector [$];
   logic [vpipe_pkg::vector_width-1:0] exp_data [$];

   int errors;
   int credits;
   int pushes;
   int returns;
   int wb_count;
   int expected_writes;
   logic [31:0] rng;

   clock_gen u_clock_gen (.clk(clk), .reset(reset));

   vector_pipeline u_vector_pipeline (
      .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
      .credit_return(credit_return), .wb_valid(wb_valid), .wb_vector(wb_vector),
      .wb_rd(wb_rd), .wb_data(wb_data)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
      if (actual !== expected) begin
         errors++;
         $display("error: %s is %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic add_entry(input vpipe_pkg::opcode_t op, input logic [2:0] rd,
                            input logic [2:0] rs1, input logic [2:0] rs2, input logic burst);
      tbl_op.push_back(op);
      tbl_rd.push_back(rd);
      tbl_rs1.push_back(rs1);
      tbl_rs2.push_back(rs2);
      tbl_burst.push_back(burst);
   endtask

   task automatic load_table();
      add_entry(vpipe_pkg::op_li,     3'd1, 3'd0, 3'd0, 1'b1);   // burst of four
      add_entry(vpipe_pkg::op_li,     3'd2, 3'd0, 3'd0, 1'b1);
      add_entry(vpipe_pkg::op_add,    3'd3, 3'd1, 3'd2, 1'b1);
      add_entry(vpipe_pkg::op_sub,    3'd4, 3'd1, 3'd2, 1'b1);
      add_entry(vpipe_pkg::op_and,    3'd5, 3'd3, 3'd4, 1'b0);
      add_entry(vpipe_pkg::op_or,     3'd6, 3'd1, 3'd5, 1'b0);
      add_entry(vpipe_pkg::op_xor,    3'd7, 3'd6, 3'd2, 1'b0);
      add_entry(vpipe_pkg::op_nop,    3'd1, 3'd1, 3'd1, 1'b0);
      add_entry(vpipe_pkg::op_li,     3'd0, 3'd0, 3'd0, 1'b0);
      add_entry(vpipe_pkg::op_vsplat, 3'd1, 3'd1, 3'd0, 1'b0);
      add_entry(vpipe_pkg::op_vsplat, 3'd2, 3'd2, 3'd0, 1'b1);
      add_entry(vpipe_pkg::op_vadd,   3'd3, 3'd1, 3'd2, 1'b1);
      add_entry(vpipe_pkg::op_vsub,   3'd4, 3'd1, 3'd2, 1'b0);
      add_entry(vpipe_pkg::op_vxor,   3'd5, 3'd3, 3'd4, 1'b0);
      add_entry(vpipe_pkg::op_nop,    3'd0, 3'd0, 3'd0, 1'b0);
      add_entry(vpipe_pkg::op_vadd,   3'd6, 3'd5, 3'd5, 1'b1);
      add_entry(vpipe_pkg::op_vsplat, 3'd7, 3'd7, 3'd0, 1'b0);
      add_entry(vpipe_pkg::op_vsub,   3'd0, 3'd7, 3'd6, 1'b0);
      add_entry(vpipe_pkg::op_li,     3'd3, 3'd0, 3'd0, 1'b1);   // second burst of four
      add_entry(vpipe_pkg::op_add,    3'd3, 3'd3, 3'd3, 1'b1);
      add_entry(vpipe_pkg::op_sub,    3'd4, 3'd3, 3'd0, 1'b1);
      add_entry(vpipe_pkg::op_vxor,   3'd1, 3'd0, 3'd7, 1'b1);
      add_entry(vpipe_pkg::op_nop,    3'd2, 3'd2, 3'd2, 1'b0);
      add_entry(vpipe_pkg::op_xor,    3'd5, 3'd4, 3'd3, 1'b0);
   endtask

   // ************************************************************************
   // reference model that runs in program order as each instruction is pushed
   // ************************************************************************
   task automatic model_instr(input vpipe_pkg::opcode_t op, input logic [2:0] rd,
                              input logic [2:0] rs1, input logic [2:0] rs2,
                              input logic [7:0] imm);
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] r;
      logic [127:0] va;
      logic [127:0] vb;
      logic [127:0] vr;
      int lane;
      a = sregs[rs1];
      b = sregs[rs2];
      va = vregs[rs1];
      vb = vregs[rs2];
      r = '0;
      vr = '0;
      for (lane = 0; lane < vpipe_pkg::lane_count; lane++) begin
         case (op)
            vpipe_pkg::op_vadd: vr[lane*8 +: 8] = va[lane*8 +: 8] + vb[lane*8 +: 8];
            vpipe_pkg::op_vsub: vr[lane*8 +: 8] = va[lane*8 +: 8] - vb[lane*8 +: 8];
            vpipe_pkg::op_vxor: vr[lane*8 +: 8] = va[lane*8 +: 8] ^ vb[lane*8 +: 8];
            vpipe_pkg::op_vsplat: vr[lane*8 +: 8] = a;
            default: vr[lane*8 +: 8] = 8'h00;
         endcase
      end
      case (op)
         vpipe_pkg::op_add: r = a + b;   // 8-bit wraparound
         vpipe_pkg::op_sub: r = a - b;
         vpipe_pkg::op_and: r = a & b;
         vpipe_pkg::op_or:  r = a | b;
         vpipe_pkg::op_xor: r = a ^ b;
         vpipe_pkg::op_li:  r = imm;
         default: r = 8'h00;
      endcase
      if (op inside {vpipe_pkg::op_vadd, vpipe_pkg::op_vsub, vpipe_pkg::op_vxor,
                     vpipe_pkg::op_vsplat}) begin
         vregs[rd] = vr;
         exp_rd.push_back(rd);
         exp_vector.push_back(1'b1);
         exp_data.push_back(vr);
      end else if (op != vpipe_pkg::op_nop) begin
         sregs[rd] = r;
         exp_rd.push_back(rd);
         exp_vector.push_back(1'b0);
         exp_data.push_back({120'b0, r});
      end
   endtask

   // outputs are sampled mid-cycle where they are stable
   always @(negedge clk) begin
      if (!reset) begin
         if (credit_return) begin
            credits++;
            returns++;
            if (credits > vpipe_pkg::queue_depth) begin
               errors++;
               $display("credit returned with no push outstanding, credits now %0d", credits);
            end
         end
         if (wb_valid) begin
            wb_count++;
            if (exp_data.size() == 0) begin
               errors++;
               $display("writeback seen with no result outstanding");
            end else begin
               check_value("wb_rd", wb_rd, exp_rd.pop_front());
               check_value("wb_vector", wb_vector, exp_vector.pop_front());
               check_value("wb_data", wb_data, exp_data.pop_front());
            end
         end
      end
   end

   // the watchdog allows twenty cycles per table row plus some start-up slack
   initial begin
      @(negedge reset);
      repeat (20 + 20 * tbl_op.size()) @(posedge clk);
      $display("timeout with %0d results still outstanding after %0d pushes",
               exp_data.size(), pushes);
      $display("Regression failed");
      $finish;
   end

   initial begin
      int i;
      int gap;
      logic [7:0] imm;
      instr_valid = 1'b0;
      instr = '0;
      errors = 0;
      credits = vpipe_pkg::queue_depth;
      pushes = 0;
      returns = 0;
      wb_count = 0;
      expected_writes = 0;
      rng = 32'd46705;
      for (i = 0; i < 8; i++) begin
         sregs[i] = '0;
         vregs[i] = '0;
      end
      load_table();

      @(negedge reset);
      // idle pipeline must stay quiet
      repeat (4) begin
         @(negedge clk);
         check_value("wb_valid", wb_valid, 1'b0);
         check_value("credit_return", credit_return, 1'b0);
      end
      @(posedge clk);

      for (i = 0; i < tbl_op.size(); i++) begin
         rng = xorshift(rng);
         gap = tbl_burst[i] ? 0 : int'(rng[1:0]);
         imm = rng[15:8];
         repeat (gap) begin
            instr_valid <= 1'b0;
            @(posedge clk);
         end
         while (credits == 0) begin
            instr_valid <= 1'b0;
            @(posedge clk);
         end
         instr_valid <= 1'b1;
         instr <= {tbl_op[i], tbl_rd[i], tbl_rs1[i], tbl_rs2[i], imm};
         credits--;
         pushes++;
         if (tbl_op[i] != vpipe_pkg::op_nop) expected_writes++;
         model_instr(tbl_op[i], tbl_rd[i], tbl_rs1[i], tbl_rs2[i], imm);
         @(posedge clk);
      end
      instr_valid <= 1'b0;

      while (exp_data.size() != 0 || returns != pushes) @(posedge clk);
      repeat (6) @(posedge clk);   // catch any stray writeback
      check_value("credit_return count", returns, pushes);
      check_value("wb_valid count", wb_count, expected_writes);

      $display("errors %0d, pushes %0d, credits returned %0d, writebacks %0d",
               errors, pushes, returns, wb_count);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* vector_pipeline.f */
design/vpipe_pkg.sv
design/instr_queue.sv
design/stall_timer.sv
design/hazard_fsm.sv
design/register_file.sv
design/decode_stage.sv
design/decode_execute_register.sv
design/execute_stage.sv
design/vector_pipeline.sv
sim/clock_gen.sv
sim/vector_pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module vector_pipeline_tb -f vector_pipeline.f -o vector_pipeline_sim

./obj_dir/vector_pipeline_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
   exit 0
else
   exit 1
fi
